/* Bender.yml */
package:
  name: multithread_issue

sources:
  - issue_pkg.sv
  - instr_wb_slave.sv
  - thread_fifo.sv
  - rr_arbiter.sv
  - thread_select_stage.sv
  - exec_writeback.sv
  - multithread_issue.sv
  - target: test
    files:
      - issue_checker.sv
      - tb_multithread_issue.sv

/* exec_writeback.sv */
////////////////////////////////////////////////////////////////////////////
// Model of the execution pipelines. Short instructions reach writeback
// short_latency cycles after issue and long ones long_latency cycles
// after issue. Both delay lines share one writeback port; the select
// stage makes sure they never deliver in the same cycle.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module exec_writeback import issue_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic issue_valid,
	input  thread_idx_t issue_thread,
	input  instr_word_t issue_instr,
	output logic wb_valid,
	output thread_idx_t wb_thread,
	output reg_idx_t wb_reg,
	output logic wb_has_dest,
	output instr_word_t wb_instr
);

	logic [short_latency - 1:0] short_valid;
	thread_idx_t short_thread [short_latency];
	instr_word_t short_instr [short_latency];
	logic [long_latency - 1:0] long_valid;
	thread_idx_t long_thread [long_latency];
	instr_word_t long_instr [long_latency];
	logic short_out;

	// Entry 0 takes the issued instruction, the last entry feeds writeback
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			short_valid <= '0;
			long_valid <= '0;
		end
		else
		begin
			short_valid <= (short_valid << 1)
				| short_latency'(issue_valid && !issue_instr[is_long_bit]);
			long_valid <= (long_valid << 1)
				| long_latency'(issue_valid && issue_instr[is_long_bit]);
		end
	end

	always_ff @(posedge clk)
	begin
		short_thread[0] <= issue_thread;
		short_instr[0] <= issue_instr;
		for (int i = 1; i < short_latency; i++)
		begin
			short_thread[i] <= short_thread[i - 1];
			short_instr[i] <= short_instr[i - 1];
		end
		long_thread[0] <= issue_thread;
		long_instr[0] <= issue_instr;
		for (int i = 1; i < long_latency; i++)
		begin
			long_thread[i] <= long_thread[i - 1];
			long_instr[i] <= long_instr[i - 1];
		end
	end

	// Merge the two lines onto the single writeback port
	assign short_out = short_valid[short_latency - 1];
	assign wb_valid = short_out || long_valid[long_latency - 1];
	assign wb_thread = short_out ? short_thread[short_latency - 1] : long_thread[long_latency - 1];
	assign wb_instr = short_out ? short_instr[short_latency - 1] : long_instr[long_latency - 1];
	assign wb_reg = wb_instr[dest_lsb +: reg_width];
	assign wb_has_dest = wb_instr[has_dest_bit];

endmodule

/* instr_wb_slave.sv */
////////////////////////////////////////////////////////////////////////////
// Wishbone classic write slave on the instruction input side.
// A write to address 0..3 enqueues the data word into that thread's FIFO.
// The ack is held off while the target FIFO is full and pulses together
// with the enqueue request. Reads are acknowledged and enqueue nothing.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module instr_wb_slave import issue_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [1:0] wb_adr,
	input  instr_word_t wb_dat,
	output logic wb_ack,
	input  logic [num_threads - 1:0] fifo_full,
	output logic enq_valid,
	output thread_idx_t enq_thread,
	output instr_word_t enq_instr
);

	thread_idx_t target;
	logic request;
	logic target_full;

	// The address low bits select the thread
	assign target = thread_idx_t'(wb_adr);
	assign target_full = fifo_full[target];

	// A new request is one that has not been acknowledged yet
	assign request = wb_cyc && wb_stb && !wb_ack;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wb_ack <= 1'b0;
			enq_valid <= 1'b0;
		end
		else
		begin
			// Writes wait for room in the FIFO, reads never wait
			wb_ack <= request && (!wb_we || !target_full);
			enq_valid <= request && wb_we && !target_full;
		end
	end

	// Payload is captured every cycle and only qualified by enq_valid
	always_ff @(posedge clk)
	begin
		enq_thread <= target;
		enq_instr <= wb_dat;
	end

endmodule

/* issue_checker.sv */
////////////////////////////////////////////////////////////////////////////
// Concurrent assertions for the thread select stage, attached with bind.
// Each failure raises an error and bumps fail_count for the testbench.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module issue_checker import issue_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic [num_threads - 1:0] grant_oh,
	input  logic [num_threads - 1:0] fifo_pop,
	input  logic [num_threads - 1:0] fifo_empty,
	input  logic [num_threads - 1:0] fifo_full,
	input  logic enq_valid,
	input  thread_idx_t enq_thread,
	input  logic wb_valid,
	input  logic wb_has_dest,
	input  thread_idx_t wb_thread,
	input  reg_idx_t wb_reg,
	input  logic [num_threads * num_regs - 1:0] sb_flat
);

	int fail_count = 0;

	// At most one thread wins a cycle
	grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant_oh))
		else
		begin
			$error("Arbiter granted more than one thread");
			fail_count++;
		end

	pop_not_empty: assert property (@(posedge clk) disable iff (reset)
		(fifo_pop & fifo_empty) == '0)
		else
		begin
			$error("Pop from an empty thread FIFO");
			fail_count++;
		end

	// Back-pressure from the bus slave keeps pushes away from full FIFOs
	push_not_full: assert property (@(posedge clk) disable iff (reset)
		enq_valid |-> !fifo_full[enq_thread])
		else
		begin
			$error("Push into a full thread FIFO");
			fail_count++;
		end

	// A writeback always frees a register that the scoreboard holds
	wb_bit_set: assert property (@(posedge clk) disable iff (reset)
		wb_valid && wb_has_dest |-> sb_flat[wb_thread * num_regs + wb_reg])
		else
		begin
			$error("Writeback for a register that is not pending");
			fail_count++;
		end

endmodule

bind thread_select_stage issue_checker chk0 (
	.clk(clk),
	.reset(reset),
	.grant_oh(grant_oh),
	.fifo_pop(fifo_pop),
	.fifo_empty(fifo_empty),
	.fifo_full(fifo_full),
	.enq_valid(enq_valid),
	.enq_thread(enq_thread),
	.wb_valid(wb_valid),
	.wb_has_dest(wb_has_dest),
	.wb_thread(wb_thread),
	.wb_reg(wb_reg),
	.sb_flat({scoreboard[3], scoreboard[2], scoreboard[1], scoreboard[0]})
);

/* issue_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared widths, types and constants for the four-thread issue stage.
// Every module imports this package with a wildcard import in its header.
// The instruction field positions below define the encoding that the
// host writes over the bus and that the select stage decodes.
////////////////////////////////////////////////////////////////////////////

package issue_pkg;

	// Thread count and per-thread storage
	localparam int num_threads = 4;
	localparam int fifo_depth = 4;
	localparam int ptr_width = $clog2(fifo_depth);
	localparam int count_width = $clog2(fifo_depth + 1);

	// Execution pipeline lengths, counted from issue_valid to wb_valid
	localparam int short_latency = 1;
	localparam int long_latency = 3;

	// Writeback slot tracking must reach past the longest pipeline
	localparam int slot_stages = 4;

	// Register file shape of one thread
	localparam int num_regs = 8;
	localparam int reg_width = 3;

	typedef logic [1:0] thread_idx_t;
	typedef logic [reg_width - 1:0] reg_idx_t;
	typedef logic [num_regs - 1:0] reg_mask_t;
	typedef logic [15:0] instr_word_t;

	// Bit positions of the instruction fields
	localparam int has_dest_bit = 15;
	localparam int dest_lsb = 12;
	localparam int has_src1_bit = 11;
	localparam int src1_lsb = 8;
	localparam int has_src2_bit = 7;
	localparam int src2_lsb = 4;
	localparam int is_long_bit = 3;
	localparam int tag_lsb = 0;
	localparam int tag_width = 3;

endpackage

/* multithread_issue.sv */
////////////////////////////////////////////////////////////////////////////
// Top level of the four-thread issue stage. The host writes decoded
// instructions over Wishbone, the select stage issues them and the
// execution model returns writebacks that release the scoreboards.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module multithread_issue import issue_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [1:0] wb_adr,
	input  instr_word_t wb_dat,
	output logic wb_ack,
	output logic issue_valid,
	output thread_idx_t issue_thread,
	output instr_word_t issue_instr,
	output logic wb_valid,
	output thread_idx_t wb_thread,
	output reg_idx_t wb_reg,
	output logic wb_has_dest,
	output instr_word_t wb_instr
);

	logic [num_threads - 1:0] fifo_full;
	logic enq_valid;
	thread_idx_t enq_thread;
	instr_word_t enq_instr;

	// Bus side, turns writes into enqueue requests
	instr_wb_slave slave0 (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack),
		.fifo_full(fifo_full),
		.enq_valid(enq_valid),
		.enq_thread(enq_thread),
		.enq_instr(enq_instr)
	);

	thread_select_stage select0 (
		.clk(clk),
		.reset(reset),
		.enq_valid(enq_valid),
		.enq_thread(enq_thread),
		.enq_instr(enq_instr),
		.fifo_full(fifo_full),
		.issue_valid(issue_valid),
		.issue_thread(issue_thread),
		.issue_instr(issue_instr),
		.wb_valid(wb_valid),
		.wb_thread(wb_thread),
		.wb_reg(wb_reg),
		.wb_has_dest(wb_has_dest)
	);

	// Writebacks loop back into the select stage scoreboards
	exec_writeback exec0 (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_thread(issue_thread),
		.issue_instr(issue_instr),
		.wb_valid(wb_valid),
		.wb_thread(wb_thread),
		.wb_reg(wb_reg),
		.wb_has_dest(wb_has_dest),
		.wb_instr(wb_instr)
	);

endmodule

/* rr_arbiter.sv */
////////////////////////////////////////////////////////////////////////////
// Round-robin arbiter over the hardware threads.
// Grants the first requester at or after the priority pointer, one-hot.
// After a grant the pointer moves to the thread after the winner.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rr_arbiter import issue_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic [num_threads - 1:0] request,
	output logic [num_threads - 1:0] grant_oh
);

	thread_idx_t ptr;
	thread_idx_t cand;
	thread_idx_t winner;
	logic found;

	// Scan the threads starting at the pointer and stop at the first request
	always_comb
	begin
		grant_oh = '0;
		found = 1'b0;
		winner = ptr;
		cand = ptr;
		for (int i = 0; i < num_threads; i++)
		begin
			cand = ptr + thread_idx_t'(i);
			if (!found && request[cand])
			begin
				found = 1'b1;
				winner = cand;
				grant_oh[cand] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ptr <= '0;
		else if (found)
			ptr <= winner + 1'b1;
	end

endmodule

/* sources.f */
issue_pkg.sv
instr_wb_slave.sv
thread_fifo.sv
rr_arbiter.sv
thread_select_stage.sv
exec_writeback.sv
multithread_issue.sv
issue_checker.sv
tb_multithread_issue.sv

/* tb_multithread_issue.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the four-thread issue stage. Writes a fixed table and then
// an LCG-driven burst of instructions over Wishbone, and checks issue order,
// register dependencies, writeback latency, fairness and back-pressure
// against a reference model kept in the monitor.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_multithread_issue import issue_pkg::*; ();

	localparam int half_period = 50;
	localparam int drive_delay = 5;
	localparam int num_table = 14;
	localparam int num_random = 24;
	localparam int burst_len = 10;
	localparam int bus_limit = 60;
	localparam int ring_size = 8;
	localparam int cycle_limit = 20 * (num_table + num_random) + 200;

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	instr_word_t wb_dat;
	logic wb_ack;
	logic issue_valid;
	thread_idx_t issue_thread;
	instr_word_t issue_instr;
	logic wb_valid;
	thread_idx_t wb_thread;
	reg_idx_t wb_reg;
	logic wb_has_dest;
	instr_word_t wb_instr;

	// Stimulus table, a position of -1 means the issue slot is not fixed
	thread_idx_t tab_thread [num_table];
	instr_word_t tab_instr [num_table];
	int tab_pos [num_table];

	// Reference model state
	instr_word_t exp_q [num_threads][$];
	reg_mask_t pending [num_threads];
	int last_wb [num_threads][num_regs];
	logic exp_valid [ring_size];
	thread_idx_t exp_thread [ring_size];
	instr_word_t exp_instr [ring_size];
	thread_idx_t log_thread [$];
	instr_word_t log_instr [$];
	int mon_cycle;
	int timeout_cycles;

	multithread_issue dut0 (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack),
		.issue_valid(issue_valid),
		.issue_thread(issue_thread),
		.issue_instr(issue_instr),
		.wb_valid(wb_valid),
		.wb_thread(wb_thread),
		.wb_reg(wb_reg),
		.wb_has_dest(wb_has_dest),
		.wb_instr(wb_instr)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#half_period clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic compare(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			abort_run($sformatf("Fail %s expected %0h actual %0h", test, expected, actual));
	endtask

	// Builds an instruction word from its fields
	function automatic instr_word_t encode(input logic hd, input int dst, input logic h1,
		input int s1, input logic h2, input int s2, input logic lng, input int tag);
		instr_word_t w;
		w = '0;
		w[has_dest_bit] = hd;
		w[dest_lsb +: reg_width] = reg_idx_t'(dst);
		w[has_src1_bit] = h1;
		w[src1_lsb +: reg_width] = reg_idx_t'(s1);
		w[has_src2_bit] = h2;
		w[src2_lsb +: reg_width] = reg_idx_t'(s2);
		w[is_long_bit] = lng;
		w[tag_lsb +: tag_width] = tag_width'(tag);
		return w;
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic set_entry(input int i, input thread_idx_t th, input instr_word_t w,
		input int pos);
		tab_thread[i] = th;
		tab_instr[i] = w;
		tab_pos[i] = pos;
	endtask

	// One Wishbone write, holding the request until ack and idling one cycle after
	task automatic bus_write(input thread_idx_t th, input instr_word_t w, output int waited);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = th;
		wb_dat = w;
		waited = 0;
		do
		begin
			@(posedge clk);
			#drive_delay;
			waited++;
			if (waited > bus_limit)
				abort_run("A Wishbone write was never acknowledged");
		end
		while (!wb_ack);
		exp_q[th].push_back(w);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(posedge clk);
		#drive_delay;
	endtask

	// Instructions still queued or writebacks still due
	function automatic int outstanding();
		int n;
		n = 0;
		for (int t = 0; t < num_threads; t++)
			n += exp_q[t].size();
		for (int s = 0; s < ring_size; s++)
			n += int'(exp_valid[s]);
		return n;
	endfunction

	task automatic wait_idle();
		while (outstanding() != 0)
		begin
			@(posedge clk);
			#drive_delay;
		end
	endtask

	// A register touched at issue must be free and released at least two cycles ago
	task automatic check_dep(input thread_idx_t t, input reg_idx_t r);
		compare($sformatf("pending t%0d r%0d", t, r), 0, pending[t][r]);
		compare($sformatf("gap t%0d r%0d", t, r), 1, (mon_cycle - last_wb[t][r]) >= 2);
	endtask

	task automatic check_writeback();
		int slot;
		thread_idx_t t;
		reg_idx_t r;
		slot = mon_cycle % ring_size;
		compare("wb_valid", exp_valid[slot], wb_valid);
		if (exp_valid[slot])
		begin
			t = exp_thread[slot];
			r = exp_instr[slot][dest_lsb +: reg_width];
			compare("wb_thread", t, wb_thread);
			compare("wb_reg", r, wb_reg);
			compare("wb_has_dest", exp_instr[slot][has_dest_bit], wb_has_dest);
			compare("wb_tag", exp_instr[slot][tag_lsb +: tag_width],
				wb_instr[tag_lsb +: tag_width]);
			// The scoreboard entry frees at the end of this cycle
			if (exp_instr[slot][has_dest_bit])
			begin
				pending[t][r] = 1'b0;
				last_wb[t][r] = mon_cycle;
			end
			exp_valid[slot] = 1'b0;
		end
	endtask

	task automatic check_issue();
		thread_idx_t t;
		instr_word_t w;
		int slot;
		t = issue_thread;
		w = issue_instr;
		if (exp_q[t].size() == 0)
			abort_run($sformatf("Thread %0d issued an instruction that was never written", t));
		compare($sformatf("issue order t%0d", t), exp_q[t].pop_front(), w);
		if (w[has_dest_bit])
			check_dep(t, w[dest_lsb +: reg_width]);
		if (w[has_src1_bit])
			check_dep(t, w[src1_lsb +: reg_width]);
		if (w[has_src2_bit])
			check_dep(t, w[src2_lsb +: reg_width]);
		if (w[has_dest_bit])
			pending[t][w[dest_lsb +: reg_width]] = 1'b1;
		// Writeback is due a fixed number of cycles later, and only one per cycle
		slot = (mon_cycle + (w[is_long_bit] ? long_latency : short_latency)) % ring_size;
		compare("writeback slot busy", 0, exp_valid[slot]);
		exp_valid[slot] = 1'b1;
		exp_thread[slot] = t;
		exp_instr[slot] = w;
		log_thread.push_back(t);
		log_instr.push_back(w);
	endtask

	// Monitor samples on the falling edge, where all DUT outputs are settled
	initial
	begin
		mon_cycle = 0;
		for (int t = 0; t < num_threads; t++)
		begin
			pending[t] = '0;
			for (int r = 0; r < num_regs; r++)
				last_wb[t][r] = -100;
		end
		for (int s = 0; s < ring_size; s++)
			exp_valid[s] = 1'b0;
		@(negedge reset);
		forever
		begin
			@(negedge clk);
			mon_cycle++;
			if (dut0.select0.chk0.fail_count != 0)
				abort_run("An assertion in the issue checker failed");
			check_writeback();
			if (issue_valid)
				check_issue();
		end
	end

	initial
	begin
		timeout_cycles = 0;
		forever
		begin
			@(posedge clk);
			timeout_cycles++;
			if (timeout_cycles > cycle_limit)
				abort_run("The run exceeded its cycle limit");
		end
	end

	initial
	begin
		int waited;
		int stalled;
		logic [31:0] seed;
		instr_word_t word;
		thread_idx_t th;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat = '0;

		// One short instruction per thread first, so issue should follow 0, 1, 2, 3
		set_entry(0, 0, encode(1, 1, 0, 0, 0, 0, 0, 0), 0);
		set_entry(1, 1, encode(1, 1, 0, 0, 0, 0, 0, 1), 1);
		set_entry(2, 2, encode(1, 1, 0, 0, 0, 0, 0, 2), 2);
		set_entry(3, 3, encode(1, 1, 0, 0, 0, 0, 0, 3), 3);
		// Long producer then a RAW consumer in thread 0
		set_entry(4, 0, encode(1, 2, 0, 0, 0, 0, 1, 4), -1);
		set_entry(5, 0, encode(1, 3, 1, 2, 0, 0, 0, 5), -1);
		// WAW on r4 in thread 1
		set_entry(6, 1, encode(1, 4, 0, 0, 0, 0, 1, 6), -1);
		set_entry(7, 1, encode(1, 4, 0, 0, 0, 0, 1, 7), -1);
		// Short RAW pair in thread 2, both sources on the same register
		set_entry(8, 2, encode(1, 5, 1, 6, 0, 0, 0, 0), -1);
		set_entry(9, 2, encode(1, 6, 1, 5, 1, 5, 0, 1), -1);
		// Long followed by a short without destination
		set_entry(10, 3, encode(1, 7, 0, 0, 0, 0, 1, 2), -1);
		set_entry(11, 3, encode(0, 0, 0, 0, 0, 0, 0, 3), -1);
		set_entry(12, 0, encode(1, 2, 1, 3, 0, 0, 0, 6), -1);
		set_entry(13, 1, encode(1, 0, 0, 0, 1, 4, 1, 3), -1);

		repeat (4) @(posedge clk);
		#drive_delay;
		reset = 1'b0;
		@(posedge clk);
		#drive_delay;

		for (int i = 0; i < num_table; i++)
			bus_write(tab_thread[i], tab_instr[i], waited);
		wait_idle();

		for (int i = 0; i < num_table; i++)
		begin
			if (tab_pos[i] >= 0)
			begin
				compare($sformatf("position %0d thread", tab_pos[i]), tab_thread[i],
					log_thread[tab_pos[i]]);
				compare($sformatf("position %0d instr", tab_pos[i]), tab_instr[i],
					log_instr[tab_pos[i]]);
			end
		end

		// Thread 0 gets a chain of long ops on r1 so its FIFO fills and ack stalls
		seed = 32'h48a5_b1a7;
		stalled = 0;
		for (int i = 0; i < num_random; i++)
		begin
			seed = lcg_next(seed);
			word = seed[31:16];
			seed = lcg_next(seed);
			if (i < burst_len)
			begin
				th = 2'd0;
				word[has_dest_bit] = 1'b1;
				word[dest_lsb +: reg_width] = 3'd1;
				word[has_src1_bit] = 1'b1;
				word[src1_lsb +: reg_width] = 3'd1;
				word[is_long_bit] = 1'b1;
			end
			else
			begin
				th = seed[25:24];
				word[has_src1_bit] = 1'b0;
				word[has_src2_bit] = 1'b0;
			end
			bus_write(th, word, waited);
			if (waited > 1)
				stalled++;
		end
		wait_idle();
		compare("back-pressure seen", 1, stalled > 0);
		compare("issued total", num_table + num_random, log_thread.size());

		if (dut0.select0.chk0.fail_count == 0)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
			abort_run("An assertion in the issue checker failed");
	end

endmodule

/* thread_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// Synchronous instruction FIFO, one instance per thread.
// The head entry is visible combinationally while the FIFO is not empty.
// Push and pop may happen in the same cycle. Callers never push when full
// and never pop when empty.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module thread_fifo import issue_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  instr_word_t push_data,
	input  logic pop,
	output instr_word_t head,
	output logic empty,
	output logic full
);

	instr_word_t mem [fifo_depth];
	logic [ptr_width - 1:0] rd_ptr;
	logic [ptr_width - 1:0] wr_ptr;
	logic [count_width - 1:0] count;

	assign head = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == count_width'(fifo_depth));

	// Pointers wrap naturally because the depth is a power of two
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;

			if (pop)
				rd_ptr <= rd_ptr + 1'b1;

			// The count only moves when exactly one side is active
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Storage array
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

endmodule

/* thread_select_stage.sv */
////////////////////////////////////////////////////////////////////////////
// Thread select stage. Holds one instruction FIFO per thread, the register
// scoreboards and the writeback slot tracker. Each cycle one eligible
// thread is picked round-robin, its head instruction is popped and the
// issue outputs are registered for the execution part.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module thread_select_stage import issue_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic enq_valid,
	input  thread_idx_t enq_thread,
	input  instr_word_t enq_instr,
	output logic [num_threads - 1:0] fifo_full,
	output logic issue_valid,
	output thread_idx_t issue_thread,
	output instr_word_t issue_instr,
	input  logic wb_valid,
	input  thread_idx_t wb_thread,
	input  reg_idx_t wb_reg,
	input  logic wb_has_dest
);

	instr_word_t head [num_threads];
	reg_mask_t scoreboard [num_threads];
	reg_mask_t dest_mask [num_threads];
	reg_mask_t clear_mask [num_threads];
	logic [num_threads - 1:0] fifo_empty;
	logic [num_threads - 1:0] fifo_pop;
	logic [num_threads - 1:0] eligible;
	logic [num_threads - 1:0] grant_oh;
	logic [slot_stages - 1:0] wb_slots;
	logic [slot_stages - 1:0] wb_slots_next;
	thread_idx_t grant_idx;
	instr_word_t grant_instr;
	logic grant_any;

	genvar t;
	generate
		for (t = 0; t < num_threads; t++)
		begin : thread_logic
			reg_mask_t dep_mask;
			logic slot_conflict;

			thread_fifo fifo0 (
				.clk(clk),
				.reset(reset),
				.push(enq_valid && enq_thread == thread_idx_t'(t)),
				.push_data(enq_instr),
				.pop(fifo_pop[t]),
				.head(head[t]),
				.empty(fifo_empty[t]),
				.full(fifo_full[t])
			);

			// Destination bit of the head instruction, set in the scoreboard at issue
			assign dest_mask[t] = head[t][has_dest_bit]
				? reg_mask_t'(1) << head[t][dest_lsb +: reg_width] : '0;

			// Sources catch RAW hazards, the destination catches WAW and WAR
			always_comb
			begin
				dep_mask = dest_mask[t];
				if (head[t][has_src1_bit])
					dep_mask |= reg_mask_t'(1) << head[t][src1_lsb +: reg_width];
				if (head[t][has_src2_bit])
					dep_mask |= reg_mask_t'(1) << head[t][src2_lsb +: reg_width];
			end

			// A short result must not land on a slot already taken by a long one
			assign slot_conflict = !head[t][is_long_bit] && wb_slots[short_latency + 1];

			assign eligible[t] = !fifo_empty[t]
				&& (scoreboard[t] & dep_mask) == '0
				&& !slot_conflict;

			// Writebacks release the register at the end of the wb_valid cycle
			assign clear_mask[t] = (wb_valid && wb_has_dest && wb_thread == thread_idx_t'(t))
				? reg_mask_t'(1) << wb_reg : '0;

			assign fifo_pop[t] = grant_oh[t];
		end
	endgenerate

	rr_arbiter arb0 (
		.clk(clk),
		.reset(reset),
		.request(eligible),
		.grant_oh(grant_oh)
	);

	// Turn the one-hot grant into a thread number
	always_comb
	begin
		grant_idx = '0;
		for (int i = 0; i < num_threads; i++)
		begin
			if (grant_oh[i])
				grant_idx = thread_idx_t'(i);
		end
	end

	assign grant_any = |grant_oh;
	assign grant_instr = head[grant_idx];

	// Bit k of the slot register marks a writeback k cycles after the current one.
	// A grant now reaches issue_valid next cycle, so its writeback lands at
	// bit latency of the next value.
	always_comb
	begin
		wb_slots_next = {1'b0, wb_slots[slot_stages - 1:1]};
		if (grant_any)
		begin
			if (grant_instr[is_long_bit])
				wb_slots_next[long_latency] = 1'b1;
			else
				wb_slots_next[short_latency] = 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			issue_valid <= 1'b0;
			wb_slots <= '0;
			for (int i = 0; i < num_threads; i++)
				scoreboard[i] <= '0;
		end
		else
		begin
			issue_valid <= grant_any;
			wb_slots <= wb_slots_next;
			for (int i = 0; i < num_threads; i++)
			begin
				scoreboard[i] <= (scoreboard[i] & ~clear_mask[i])
					| (grant_oh[i] ? dest_mask[i] : '0);
			end
		end
	end

	// Issue payload, qualified by issue_valid
	always_ff @(posedge clk)
	begin
		issue_thread <= grant_idx;
		issue_instr <= grant_instr;
	end

endmodule
